//--- processador_defines.svh
`ifndef PROCESSADOR_DEFINES_SVH
`define PROCESSADOR_DEFINES_SVH

// words on the simulated disk
`define DISK_SIZE 300

// general purpose registers, r0 reads zero
`define REG_COUNT 32

// data memory depth, addressed by the low bits of the computed address
`define DATA_WORDS 64

// width of the output port number
`define OUT_PORT_BITS 2

`endif

//--- processador_pkg.sv
package processador_pkg;

	typedef logic [31:0] word_t; // data and instruction word

	// primary opcodes, instr[31:26]
	typedef enum logic [5:0] {
		op_rtype      = 6'd0,
		op_addi       = 6'd1,
		op_subi       = 6'd2,
		op_mov        = 6'd14,
		op_lw         = 6'd15,
		op_li         = 6'd16,
		op_la         = 6'd17,
		op_sw         = 6'd18,
		op_in         = 6'd19,
		op_out        = 6'd20,
		op_jf         = 6'd21,
		op_j          = 6'd22,
		op_jal        = 6'd23,
		op_halt       = 6'd24,
		op_prog_begin = 6'd25,
		op_prog_end   = 6'd26
	} opcode_t;

	// r-type function field, instr[5:0]
	typedef enum logic [5:0] {
		fn_add = 6'd0,
		fn_ne  = 6'd13,
		fn_lt  = 6'd14,
		fn_jr  = 6'd18
	} funct_t;

	typedef enum logic [2:0] {
		alu_add,      // rs + rt
		alu_sub,      // rs - imm
		alu_lt,       // signed rs < rt
		alu_ne,       // rs != rt
		alu_pass_a,   // rs
		alu_pass_imm, // imm
		alu_add_imm   // rs + imm
	} alu_op_t;

	typedef enum logic [1:0] {
		br_none,
		br_jump_imm,
		br_jump_reg,
		br_jump_if_false
	} branch_t;

endpackage

//--- disco_rigido.sv
`timescale 1ns/1ns
`include "processador_defines.svh"

module disco_rigido (
	input  logic [25:0]            setor,
	output processador_pkg::word_t dados
);
	import processador_pkg::*;

	localparam int sector_bits = $clog2(`DISK_SIZE);

	word_t disk [`DISK_SIZE];

	always_comb begin
		for (int i = 0; i < `DISK_SIZE; i++) begin
			disk[i] = '0; // unused sectors read zero
		end
		disk[0]  = 32'b010110_00000000000000000000101110; // go to main
		disk[1]  = 32'b011001_00000000000000000000000000; // program begin marker
		// sort routine: frame setup
		disk[2]  = 32'b000001_11110_11110_0000000000001000;
		disk[3]  = 32'b010010_11110_00110_1111111111111011; // save array base
		disk[4]  = 32'b010010_11110_00111_1111111111111100; // save length
		disk[5]  = 32'b010000_00000_10100_0000000000000000;
		disk[6]  = 32'b010010_11110_10100_1111111111111101; // i = 0
		disk[7]  = 32'b001111_11110_01010_1111111111111100; // outer loop head
		disk[8]  = 32'b000010_01010_10101_0000000000000001;
		disk[9]  = 32'b001111_11110_01011_1111111111111101;
		disk[10] = 32'b000000_01011_10101_10110_00000_001110;
		disk[11] = 32'b010101_10110_00000_0000000000101101; // exit when i >= n-1
		disk[12] = 32'b010010_11110_01011_1111111111111111; // min = i
		disk[13] = 32'b000001_01011_10111_0000000000000001;
		disk[14] = 32'b010010_11110_10111_1111111111111110; // j = i + 1
		disk[15] = 32'b001111_11110_01100_1111111111111110; // inner loop head
		disk[16] = 32'b000000_01100_01010_11000_00000_001110;
		disk[17] = 32'b010101_11000_00000_0000000000011101;
		disk[18] = 32'b001111_11110_01101_1111111111111011;
		disk[19] = 32'b000000_01101_01100_11001_00000_000000;
		disk[20] = 32'b001111_11001_11001_0000000000000000; // a[j]
		disk[21] = 32'b001111_11110_01110_1111111111111111;
		disk[22] = 32'b000000_01101_01110_11010_00000_000000;
		disk[23] = 32'b001111_11010_11010_0000000000000000; // a[min]
		disk[24] = 32'b000000_11001_11010_11011_00000_001110;
		disk[25] = 32'b010101_11011_00000_0000000000011010;
		disk[26] = 32'b010010_11110_01100_1111111111111111; // min = j
		disk[27] = 32'b000001_01100_11100_0000000000000001;
		disk[28] = 32'b010010_11110_11100_1111111111111110;
		disk[29] = 32'b010110_00000000000000000000001110;
		// swap a[i] and a[min] when they differ
		disk[30] = 32'b001111_11110_01111_1111111111111111;
		disk[31] = 32'b000000_01011_01111_11101_00000_001101;
		disk[32] = 32'b010101_11101_00000_0000000000101010;
		disk[33] = 32'b000000_01101_01011_10100_00000_000000;
		disk[34] = 32'b001111_10100_10100_0000000000000000;
		disk[35] = 32'b010010_11110_10100_0000000000000000; // temp = a[i]
		disk[36] = 32'b000000_01101_01111_10101_00000_000000;
		disk[37] = 32'b001111_10101_10101_0000000000000000;
		disk[38] = 32'b000000_01101_01011_10110_00000_000000;
		disk[39] = 32'b010010_10110_10101_0000000000000000;
		disk[40] = 32'b000000_01101_01111_10111_00000_000000;
		disk[41] = 32'b001111_11110_10000_0000000000000000;
		disk[42] = 32'b010010_10111_10000_0000000000000000;
		disk[43] = 32'b000001_01011_11000_0000000000000001;
		disk[44] = 32'b010010_11110_11000_1111111111111101; // i = i + 1
		disk[45] = 32'b010110_00000000000000000000000110;
		disk[46] = 32'b000000_11111_00000_00000_00000_010010; // return
		// main: store 9, 6, 8, 7 and call sort
		disk[47] = 32'b000001_11110_11110_0000000000000101;
		disk[48] = 32'b010001_11110_01010_1111111111111100;
		disk[49] = 32'b010000_00000_10100_0000000000001001;
		disk[50] = 32'b010010_01010_10100_0000000000000000;
		disk[51] = 32'b010000_00000_10101_0000000000000110;
		disk[52] = 32'b010010_01010_10101_0000000000000001;
		disk[53] = 32'b010000_00000_10110_0000000000001000;
		disk[54] = 32'b010010_01010_10110_0000000000000010;
		disk[55] = 32'b010000_00000_10111_0000000000000111;
		disk[56] = 32'b010010_01010_10111_0000000000000011;
		disk[57] = 32'b010001_11110_00110_1111111111111100;
		disk[58] = 32'b010000_00000_00111_0000000000000100;
		disk[59] = 32'b010111_00000000000000000000000001; // call sort
		disk[60] = 32'b001110_00001_01011_0000000000000000;
		disk[61] = 32'b000010_11110_11110_0000000000001000;
		disk[62] = 32'b010011_00000_11000_0000000000000000; // read index
		disk[63] = 32'b010010_11110_11000_0000000000000000;
		disk[64] = 32'b010001_11110_01100_1111111111111100;
		disk[65] = 32'b001111_11110_01101_0000000000000000;
		disk[66] = 32'b000000_01100_01101_11001_00000_000000;
		disk[67] = 32'b001111_11001_11001_0000000000000000; // selected element
		disk[68] = 32'b001110_11001_00110_0000000000000000;
		disk[69] = 32'b010000_00000_00111_0000000000000010;
		disk[70] = 32'b010100_00000_00110_0000000000000010; // send to port 2
		disk[71] = 32'b011000_00000000000000000000000000;
		disk[72] = 32'b011010_00000000000000000000000000; // program end marker
	end

	assign dados = (setor < 26'(`DISK_SIZE)) ? disk[setor[sector_bits-1:0]] : '0;

endmodule

//--- sequencer.sv
`timescale 1ns/1ns

module sequencer (
	input  logic                   clock,
	input  logic                   rst,
	input  logic                   step_done,
	input  processador_pkg::word_t next_pc,
	input  logic                   is_halt,
	output processador_pkg::word_t pc,
	output logic                   state_decode,
	output logic                   state_execute,
	output logic                   state_result,
	output logic                   halted
);

	typedef enum logic [1:0] {
		st_fetch,
		st_decode,
		st_execute,
		st_result
	} state_t;

	state_t state;

	assign state_decode  = (state == st_decode);
	assign state_execute = (state == st_execute);
	assign state_result  = (state == st_result);

	always_ff @(posedge clock) begin
		if (rst) begin
			state  <= st_fetch;
			pc     <= '0;
			halted <= 1'b0;
		end else if (!halted) begin
			case (state)
				st_fetch: begin
					state <= st_decode; // disk word settles on pc
				end
				st_decode: begin
					state <= st_execute;
				end
				st_execute: begin
					state <= st_result;
				end
				st_result: begin
					if (step_done) begin // i/o may hold us here
						state <= st_fetch;
						if (is_halt) begin
							halted <= 1'b1; // pc stays on the halt word
						end else begin
							pc <= next_pc;
						end
					end
				end
				default: state <= st_fetch;
			endcase
		end
	end

endmodule

//--- decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
	input  logic                     clock,
	input  logic                     rst,
	input  logic                     state_decode,
	input  processador_pkg::word_t   instr,
	output logic [4:0]               rs_idx,
	output logic [4:0]               rt_idx,
	output logic [4:0]               dest_idx,
	output processador_pkg::word_t   imm,
	output processador_pkg::alu_op_t alu_op,
	output processador_pkg::branch_t branch,
	output logic                     reg_write,
	output logic                     mem_read,
	output logic                     mem_write,
	output logic                     is_in,
	output logic                     is_out,
	output logic                     is_halt
);
	import processador_pkg::*;

	word_t      instr_q;
	opcode_t    opcode;
	funct_t     funct;
	logic [4:0] rd_idx;

	assign opcode = opcode_t'(instr_q[31:26]);
	assign funct  = funct_t'(instr_q[5:0]);
	assign rs_idx = instr_q[25:21];
	assign rt_idx = instr_q[20:16];
	assign rd_idx = instr_q[15:11];

	always_ff @(posedge clock) begin
		if (rst) begin
			instr_q <= '0;
		end else if (state_decode) begin
			instr_q <= instr; // held through execute and result
		end
	end

	always_comb begin
		imm       = {{16{instr_q[15]}}, instr_q[15:0]};
		dest_idx  = rt_idx;
		alu_op    = alu_pass_imm;
		branch    = br_none;
		reg_write = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		is_in     = 1'b0;
		is_out    = 1'b0;
		is_halt   = 1'b0;
		case (opcode)
			op_rtype: begin
				dest_idx = rd_idx;
				case (funct)
					fn_add: begin
						alu_op    = alu_add;
						reg_write = 1'b1;
					end
					fn_lt: begin
						alu_op    = alu_lt;
						reg_write = 1'b1;
					end
					fn_ne: begin
						alu_op    = alu_ne;
						reg_write = 1'b1;
					end
					fn_jr: branch = br_jump_reg;
					default: ; // unknown function is a no-op
				endcase
			end
			op_addi, op_la: begin
				alu_op    = alu_add_imm;
				reg_write = 1'b1;
			end
			op_subi: begin
				alu_op    = alu_sub;
				reg_write = 1'b1;
			end
			op_mov: begin
				alu_op    = alu_pass_a;
				reg_write = 1'b1;
			end
			op_li: reg_write = 1'b1;
			op_lw: begin
				alu_op    = alu_add_imm;
				reg_write = 1'b1;
				mem_read  = 1'b1;
			end
			op_sw: begin
				alu_op    = alu_add_imm; // data comes from rt
				mem_write = 1'b1;
			end
			op_in: begin
				reg_write = 1'b1;
				is_in     = 1'b1;
			end
			op_out: is_out = 1'b1; // port number rides on alu_result
			op_jf: branch = br_jump_if_false;
			op_j: begin
				imm    = {6'b0, instr_q[25:0]};
				branch = br_jump_imm;
			end
			op_jal: begin
				imm       = {6'b0, instr_q[25:0]};
				branch    = br_jump_imm;
				dest_idx  = 5'd31; // link register
				reg_write = 1'b1;
			end
			op_halt: is_halt = 1'b1;
			op_prog_begin, op_prog_end: ; // markers only
			default: ;
		endcase
	end

endmodule

//--- execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
	input  processador_pkg::word_t   rs_value,
	input  processador_pkg::word_t   rt_value,
	input  processador_pkg::word_t   imm,
	input  processador_pkg::word_t   pc,
	input  processador_pkg::alu_op_t alu_op,
	input  processador_pkg::branch_t branch,
	output processador_pkg::word_t   alu_result,
	output processador_pkg::word_t   next_pc
);
	import processador_pkg::*;

	word_t seq_pc;
	word_t target;

	assign seq_pc = pc + 32'd1;

	// jump fields name the word just before the destination
	assign target = imm + 32'd1;

	always_comb begin
		case (alu_op)
			alu_add:      alu_result = rs_value + rt_value;
			alu_add_imm:  alu_result = rs_value + imm; // also lw/sw address
			alu_sub:      alu_result = rs_value - imm;
			alu_lt:       alu_result = {31'b0, $signed(rs_value) < $signed(rt_value)};
			alu_ne:       alu_result = {31'b0, rs_value != rt_value};
			alu_pass_a:   alu_result = rs_value;
			alu_pass_imm: alu_result = imm;
			default:      alu_result = '0;
		endcase
	end

	always_comb begin
		case (branch)
			br_jump_imm: next_pc = target;
			br_jump_reg: next_pc = rs_value; // return address already past the call
			br_jump_if_false: begin
				next_pc = (rs_value == '0) ? target : seq_pc;
			end
			default: next_pc = seq_pc;
		endcase
	end

endmodule

//--- result_stage.sv
`timescale 1ns/1ns
`include "processador_defines.svh"

module result_stage (
	input  logic                       clock,
	input  logic                       rst,
	input  logic                       state_result,
	input  logic [4:0]                 rs_idx,
	input  logic [4:0]                 rt_idx,
	input  logic [4:0]                 dest_idx,
	input  processador_pkg::word_t     alu_result,
	input  processador_pkg::word_t     pc,
	input  logic                       reg_write,
	input  logic                       mem_read,
	input  logic                       mem_write,
	input  logic                       is_in,
	input  logic                       is_out,
	input  logic                       is_jal,
	output processador_pkg::word_t     rs_value,
	output processador_pkg::word_t     rt_value,
	output logic                       in_req,
	input  logic                       in_ack,
	input  processador_pkg::word_t     in_data,
	output logic                       out_req,
	input  logic                       out_ack,
	output processador_pkg::word_t     out_data,
	output logic [`OUT_PORT_BITS-1:0]  out_port,
	output logic                       step_done
);
	import processador_pkg::*;

	localparam int addr_bits = $clog2(`DATA_WORDS);

	typedef enum logic [1:0] {
		io_idle,
		io_ack_wait,
		io_rel_wait,
		io_done
	} io_state_t;

	word_t                regs [`REG_COUNT];
	word_t                dmem [`DATA_WORDS];
	io_state_t            io_state;
	logic [addr_bits-1:0] mem_addr;
	logic                 one_cycle;
	logic                 dest_ok;
	word_t                wb_value;

	assign rs_value  = (rs_idx == 5'd0) ? '0 : regs[rs_idx];
	assign rt_value  = (rt_idx == 5'd0) ? '0 : regs[rt_idx];
	assign mem_addr  = alu_result[addr_bits-1:0];
	assign one_cycle = state_result && !is_in && !is_out;
	assign dest_ok   = reg_write && (dest_idx != 5'd0);
	assign wb_value  = is_jal ? pc + 32'd1 : (mem_read ? dmem[mem_addr] : alu_result);
	assign step_done = one_cycle || (io_state == io_done);

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
			for (int i = 0; i < `DATA_WORDS; i++) begin
				dmem[i] <= '0;
			end
			io_state <= io_idle;
			in_req   <= 1'b0;
			out_req  <= 1'b0;
		end else begin
			if (one_cycle) begin
				if (dest_ok) regs[dest_idx] <= wb_value;
				if (mem_write) dmem[mem_addr] <= rt_value;
			end
			case (io_state)
				io_idle: begin
					if (state_result && is_in) begin
						in_req   <= 1'b1;
						io_state <= io_ack_wait;
					end else if (state_result && is_out) begin
						out_req  <= 1'b1;
						io_state <= io_ack_wait;
					end
				end
				io_ack_wait: begin
					if (is_in && in_ack) begin
						if (dest_ok) regs[dest_idx] <= in_data; // sampled with ack
						in_req   <= 1'b0;
						io_state <= io_rel_wait;
					end else if (is_out && out_ack) begin
						out_req  <= 1'b0;
						io_state <= io_rel_wait;
					end
				end
				io_rel_wait: begin
					if ((is_in && !in_ack) || (is_out && !out_ack)) begin
						io_state <= io_done; // ack released, finish next cycle
					end
				end
				default: io_state <= io_idle;
			endcase
		end
	end

	// value and port latched as the request rises
	always_ff @(posedge clock) begin
		if (io_state == io_idle && state_result && is_out) begin
			out_data <= rt_value;
			out_port <= alu_result[`OUT_PORT_BITS-1:0];
		end
	end

endmodule

//--- processador.sv
`timescale 1ns/1ns
`include "processador_defines.svh"

module processador (
	input  logic                      clock,
	input  logic                      rst,
	output logic                      in_req,
	input  logic                      in_ack,
	input  processador_pkg::word_t    in_data,
	output logic                      out_req,
	input  logic                      out_ack,
	output processador_pkg::word_t    out_data,
	output logic [`OUT_PORT_BITS-1:0] out_port,
	output logic                      halted
);
	import processador_pkg::*;

	word_t      pc;
	word_t      instr;
	word_t      next_pc;
	word_t      imm;
	word_t      rs_value;
	word_t      rt_value;
	word_t      alu_result;
	alu_op_t    alu_op;
	branch_t    branch;
	logic [4:0] rs_idx;
	logic [4:0] rt_idx;
	logic [4:0] dest_idx;
	logic       state_decode;
	logic       state_result;
	logic       step_done;
	logic       reg_write;
	logic       mem_read;
	logic       mem_write;
	logic       is_in;
	logic       is_out;
	logic       is_halt;
	logic       is_jal;

	assign is_jal = (branch == br_jump_imm) && reg_write; // j never writes a register

	disco_rigido disco_i (
		.setor (pc[25:0]),
		.dados (instr)
	);

	sequencer sequencer_i (
		.clock         (clock),
		.rst           (rst),
		.step_done     (step_done),
		.next_pc       (next_pc),
		.is_halt       (is_halt),
		.pc            (pc),
		.state_decode  (state_decode),
		.state_execute (),
		.state_result  (state_result),
		.halted        (halted)
	);

	decode_stage decode_i (
		.clock        (clock),
		.rst          (rst),
		.state_decode (state_decode),
		.instr        (instr),
		.rs_idx       (rs_idx),
		.rt_idx       (rt_idx),
		.dest_idx     (dest_idx),
		.imm          (imm),
		.alu_op       (alu_op),
		.branch       (branch),
		.reg_write    (reg_write),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.is_in        (is_in),
		.is_out       (is_out),
		.is_halt      (is_halt)
	);

	execute_stage execute_i (
		.rs_value   (rs_value),
		.rt_value   (rt_value),
		.imm        (imm),
		.pc         (pc),
		.alu_op     (alu_op),
		.branch     (branch),
		.alu_result (alu_result),
		.next_pc    (next_pc)
	);

	result_stage result_i (
		.clock        (clock),
		.rst          (rst),
		.state_result (state_result),
		.rs_idx       (rs_idx),
		.rt_idx       (rt_idx),
		.dest_idx     (dest_idx),
		.alu_result   (alu_result),
		.pc           (pc),
		.reg_write    (reg_write),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.is_in        (is_in),
		.is_out       (is_out),
		.is_jal       (is_jal),
		.rs_value     (rs_value),
		.rt_value     (rt_value),
		.in_req       (in_req),
		.in_ack       (in_ack),
		.in_data      (in_data),
		.out_req      (out_req),
		.out_ack      (out_ack),
		.out_data     (out_data),
		.out_port     (out_port),
		.step_done    (step_done)
	);

endmodule

//--- processador_checker.sv
`timescale 1ns/1ns
`include "processador_defines.svh"

module processador_checker (
	input  logic                      clock,
	input  logic                      rst,
	input  logic                      in_req,
	input  logic                      in_ack,
	input  logic                      out_req,
	input  logic                      out_ack,
	input  processador_pkg::word_t    out_data,
	input  logic [`OUT_PORT_BITS-1:0] out_port,
	input  logic                      halted,
	input  processador_pkg::word_t    expected_value,
	input  int                        test_index,
	input  logic                      test_end,
	output int                        error_count,
	output int                        tests_done,
	output int                        tests_passed
);
	import processador_pkg::*;

	int                        errors_total = 0;
	int                        done_total   = 0;
	int                        pass_total   = 0;
	int                        test_errors  = 0;
	int                        in_count     = 0;
	int                        out_count    = 0;
	logic                      in_ack_seen  = 1'b0;
	logic                      out_ack_seen = 1'b0;
	logic                      out_done     = 1'b0;
	logic                      rst_q        = 1'b0;
	logic                      in_req_q     = 1'b0;
	logic                      out_req_q    = 1'b0;
	logic                      out_ack_q    = 1'b0;
	logic                      halted_q     = 1'b0;
	word_t                     data_held    = '0;
	logic [`OUT_PORT_BITS-1:0] port_held    = '0;

	assign error_count  = errors_total;
	assign tests_done   = done_total;
	assign tests_passed = pass_total;

	task automatic report_failure(input string what);
		errors_total++;
		test_errors++;
		$display("ERROR t=%0t %s", $time, what);
	endtask

	task automatic compare_value(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			errors_total++;
			test_errors++;
			$display("ERROR t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	// sampled mid-cycle, away from both the DUT edge and the drive edge
	always @(negedge clock) begin
		if (rst) begin
			in_count     = 0;
			out_count    = 0;
			test_errors  = 0;
			in_ack_seen  = 1'b0;
			out_ack_seen = 1'b0;
			out_done     = 1'b0;
		end else begin
			if (rst_q && (in_req || out_req || halted)) begin
				report_failure("in_req, out_req or halted is high right after reset");
			end
			if (in_req && !in_req_q) begin
				in_count++;
				if (in_count > 1) report_failure("a second input request was raised");
				if (out_count != 0) report_failure("input request came after the output request");
				if (halted_q) report_failure("input request raised after halt");
			end
			if (in_req && in_ack) in_ack_seen = 1'b1;
			if (!in_req && in_req_q && !in_ack_seen) begin
				report_failure("in_req fell before in_ack rose");
			end
			if (out_req && !out_req_q) begin
				out_count++;
				if (out_count > 1) report_failure("a second output request was raised");
				if (in_count == 0) report_failure("output request came before any input request");
				if (halted_q) report_failure("output request raised after halt");
				compare_value("out_data", out_data, expected_value);
				compare_value("out_port", word_t'(out_port), 32'd2); // sort result goes to port 2
				data_held = out_data;
				port_held = out_port;
			end else if (out_req && out_req_q) begin
				compare_value("out_data while out_req high", out_data, data_held);
				compare_value("out_port while out_req high", word_t'(out_port),
					word_t'(port_held));
			end
			if (out_req && out_ack) out_ack_seen = 1'b1;
			if (!out_req && out_req_q && !out_ack_seen) begin
				report_failure("out_req fell before out_ack rose");
			end
			if (!out_ack && out_ack_q && !out_req) out_done = 1'b1; // four phases finished
			if (halted && !halted_q && !out_done) begin
				report_failure("halted rose before the output handshake completed");
			end
			if (!halted && halted_q) report_failure("halted fell after it had risen");
			if (test_end) begin
				if (in_count != 1) begin
					report_failure($sformatf("expected one input request, saw %0d", in_count));
				end
				if (out_count != 1) begin
					report_failure($sformatf("expected one output request, saw %0d", out_count));
				end
				if (!halted) report_failure("halted is low at the end of the test");
				done_total++;
				if (test_errors == 0) begin
					pass_total++;
					$display("test %0d (index %0d): pass", done_total, test_index);
				end else begin
					$display("test %0d (index %0d): FAIL with %0d errors", done_total,
						test_index, test_errors);
				end
			end
		end
		rst_q     = rst;
		in_req_q  = in_req;
		out_req_q = out_req;
		out_ack_q = out_ack;
		halted_q  = halted;
	end

endmodule

//--- processador_tb.sv
`timescale 1ns/1ns
`include "processador_defines.svh"

module processador_tb;
	import processador_pkg::*;

	localparam int n_tests         = 4;
	localparam int cycles_per_test = 3000;
	localparam int drive_delay     = 2;

	logic                      clock;
	logic                      rst;
	logic                      in_req;
	logic                      in_ack;
	word_t                     in_data;
	logic                      out_req;
	logic                      out_ack;
	word_t                     out_data;
	logic [`OUT_PORT_BITS-1:0] out_port;
	logic                      halted;

	word_t      expected_value;
	int         test_index;
	logic       test_end;
	int         error_count;
	int         tests_done;
	int         tests_passed;
	logic [7:0] lfsr_state = 8'd98;

	// index fed to the in instruction, and the element of the sorted {6,7,8,9}
	int    table_index    [n_tests] = '{2, 0, 3, 1};
	word_t table_expected [n_tests] = '{32'd8, 32'd6, 32'd9, 32'd7};

	processador dut_i (
		.clock    (clock),
		.rst      (rst),
		.in_req   (in_req),
		.in_ack   (in_ack),
		.in_data  (in_data),
		.out_req  (out_req),
		.out_ack  (out_ack),
		.out_data (out_data),
		.out_port (out_port),
		.halted   (halted)
	);

	processador_checker checker_i (
		.clock          (clock),
		.rst            (rst),
		.in_req         (in_req),
		.in_ack         (in_ack),
		.out_req        (out_req),
		.out_ack        (out_ack),
		.out_data       (out_data),
		.out_port       (out_port),
		.halted         (halted),
		.expected_value (expected_value),
		.test_index     (test_index),
		.test_end       (test_end),
		.error_count    (error_count),
		.tests_done     (tests_done),
		.tests_passed   (tests_passed)
	);

	// x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic next_random_bit();
		logic feedback;
		logic out_bit;
		out_bit    = lfsr_state[7];
		feedback   = lfsr_state[7] ^ lfsr_state[5] ^ lfsr_state[4] ^ lfsr_state[3];
		lfsr_state = {lfsr_state[6:0], feedback};
		return out_bit;
	endfunction

	function automatic int random_delay();
		int value;
		value = 0;
		for (int b = 0; b < 3; b++) begin
			value = (value << 1) | int'(next_random_bit()); // three bits, 0 to 7
		end
		return value;
	endfunction

	task automatic next_cycle();
		@(posedge clock);
		#drive_delay;
	endtask

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// input device
	initial begin
		int wait_cycles;
		in_ack  = 1'b0;
		in_data = '0;
		forever begin
			next_cycle();
			if (in_req && !in_ack) begin
				wait_cycles = random_delay();
				repeat (wait_cycles) next_cycle();
				in_data = word_t'(test_index);
				in_ack  = 1'b1;
				while (in_req) next_cycle();
				wait_cycles = random_delay();
				repeat (wait_cycles) next_cycle();
				in_ack = 1'b0;
			end
		end
	end

	// output device
	initial begin
		int wait_cycles;
		out_ack = 1'b0;
		forever begin
			next_cycle();
			if (out_req && !out_ack) begin
				wait_cycles = random_delay();
				repeat (wait_cycles) next_cycle();
				out_ack = 1'b1;
				while (out_req) next_cycle();
				wait_cycles = random_delay();
				repeat (wait_cycles) next_cycle();
				out_ack = 1'b0;
			end
		end
	end

	initial begin
		rst            = 1'b1;
		test_end       = 1'b0;
		test_index     = 0;
		expected_value = '0;
		for (int i = 0; i < n_tests; i++) begin
			test_index     = table_index[i];
			expected_value = table_expected[i];
			rst            = 1'b1;
			repeat (5) next_cycle();
			rst = 1'b0;
			while (!halted) next_cycle();
			repeat (50) next_cycle(); // quiet window after halt
			test_end = 1'b1;
			next_cycle();
			test_end = 1'b0;
		end
		$display("tests run: %0d, passed: %0d, errors: %0d", tests_done, tests_passed,
			error_count);
		if (error_count == 0 && tests_done == n_tests) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (n_tests * cycles_per_test) @(posedge clock);
		$display("TIMEOUT: the run did not finish within %0d cycles",
			n_tests * cycles_per_test);
		$display("Done: errors found");
		$finish;
	end

endmodule

//--- processador.f
+incdir+.
processador_pkg.sv
disco_rigido.sv
sequencer.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
processador.sv
processador_checker.sv
processador_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --top-module processador_tb -f processador.f
./obj_dir/Vprocessador_tb | tee sim.log

if grep -qx "Done: no errors" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
